//--- verilog/rv_config.svh
// core-wide sizes and constants, included by the package, the RTL and the testbench
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data word and program counter widths
`define RV_XLEN 32
`define RV_PC_W 10
`define RV_REG_CNT 32

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013
`define RV_SIM_CYCLES 20000

`endif

//--- verilog/rv_pkg.sv
// instruction views, opcodes and pipeline register types shared by the core and its checker
`default_nettype none
`include "rv_config.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;

	// ------------------------------------------------------------------------
	// opcodes and alu operations
	// ------------------------------------------------------------------------
	localparam logic [6:0] OP_R      = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;

	localparam logic [3:0] ALU_ADD = 4'd0;
	localparam logic [3:0] ALU_SUB = 4'd1;
	localparam logic [3:0] ALU_AND = 4'd2;
	localparam logic [3:0] ALU_OR  = 4'd3;
	localparam logic [3:0] ALU_SLT = 4'd4;

	// ------------------------------------------------------------------------
	// instruction word
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		j_fmt_t j_fmt;
	} instr_u;

	// ------------------------------------------------------------------------
	// pipeline registers
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [3:0] alu_ctrl;
		logic       alu_src;
		logic       mem_read;
		logic       mem_write;
		logic       mem_to_reg;
		logic       reg_write;
		logic       branch;
		logic       branch_ne;
		logic       link;
	} ctrl_t;

	typedef struct packed {
		ctrl_t              ctrl;
		word_t              rs1_data;
		word_t              rs2_data;
		word_t              imm;
		logic [4:0]         rs1;
		logic [4:0]         rs2;
		logic [4:0]         rd;
		logic [`RV_PC_W-1:0] pc_link;
		logic [`RV_PC_W-1:0] br_target;
	} id_ex_t;

	typedef struct packed {
		logic               mem_read;
		logic               mem_write;
		logic               mem_to_reg;
		logic               reg_write;
		logic               link;
		word_t              alu_result;
		word_t              store_data;
		logic [4:0]         rd;
		logic [`RV_PC_W-1:0] pc_link;
	} ex_mem_t;

	typedef struct packed {
		logic               reg_write;
		logic               mem_to_reg;
		logic               link;
		word_t              alu_result;
		word_t              mem_data;
		logic [4:0]         rd;
		logic [`RV_PC_W-1:0] pc_link;
	} mem_wb_t;

	// 0 regfile, 1 ex/mem result, 2 writeback value
	typedef struct packed {
		logic [1:0] rs1_sel;
		logic [1:0] rs2_sel;
	} fwd_t;

endpackage

`default_nettype wire

//--- verilog/rv_decode.sv
// decode stage: control bits, alu operation and sign-extended immediate from one instruction
`default_nettype none
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
	input  instr_u instr,
	output ctrl_t  ctrl,
	output word_t  imm
);

	// funct3 picks the operation, sub only for register ops
	function automatic logic [3:0] alu_op(input logic [2:0] funct3, input logic sub);
		logic [3:0] op;
		case (funct3)
			3'b000:  op = sub ? ALU_SUB : ALU_ADD;
			3'b010:  op = ALU_SLT;
			3'b110:  op = ALU_OR;
			3'b111:  op = ALU_AND;
			default: op = ALU_ADD;
		endcase
		return op;
	endfunction

	always_comb begin
		ctrl = '0;
		imm  = '0;
		case (instr.r_fmt.opcode)
			OP_R: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_ctrl  = alu_op(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
			end
			OP_IMM: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_ctrl  = alu_op(instr.i_fmt.funct3, 1'b0);
				imm = word_t'($signed(instr.i_fmt.imm));
			end
			OP_LOAD: begin
				ctrl.reg_write  = 1'b1;
				ctrl.alu_src    = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				imm = word_t'($signed(instr.i_fmt.imm));
			end
			OP_STORE: begin
				ctrl.alu_src   = 1'b1;
				ctrl.mem_write = 1'b1;
				imm = word_t'($signed({instr.s_fmt.imm_hi, instr.s_fmt.imm_lo}));
			end
			OP_BRANCH: begin
				// compare by subtraction, bne when funct3[0]
				ctrl.branch    = 1'b1;
				ctrl.branch_ne = instr.b_fmt.funct3[0];
				ctrl.alu_ctrl  = ALU_SUB;
				imm = word_t'($signed({instr.b_fmt.imm_12, instr.b_fmt.imm_11,
					instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0}));
			end
			OP_JAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.link      = 1'b1;
				imm = word_t'($signed({instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
					instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0}));
			end
			OP_JALR: begin
				ctrl.reg_write = 1'b1;
				ctrl.link      = 1'b1;
				imm = word_t'($signed(instr.i_fmt.imm));
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/rv_regfile.sv
// integer register file, two read ports for decode and one write port from writeback
`default_nettype none
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_regfile import rv_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [4:0] rs1,
	input  logic [4:0] rs2,
	input  logic [4:0] rd,
	input  logic       wen,
	input  word_t      wdata,
	output word_t      rs1_data,
	output word_t      rs2_data
);

	word_t regs [`RV_REG_CNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `RV_REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	// write-through so writeback lands in the same cycle's decode
	assign rs1_data = (rs1 == 5'd0) ? '0 : (wen && rs1 == rd) ? wdata : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? '0 : (wen && rs2 == rd) ? wdata : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/rv_alu.sv
// execute-stage alu for the supported integer ops, zero flag feeds the branch decision
`default_nettype none
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
	input  word_t      a,
	input  word_t      b,
	input  logic [3:0] alu_ctrl,
	output word_t      result,
	output logic       zero
);

	always_comb begin
		case (alu_ctrl)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			// signed compare
			ALU_SLT: result = word_t'($signed(a) < $signed(b));
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- verilog/rv_hazard.sv
// hazard unit: execute forwarding selects, jalr operand select, load-use stall and flushes
`default_nettype none
`timescale 1ns/1ps

module rv_hazard import rv_pkg::*; (
	input  logic       [4:0] id_rs1,
	input  logic       [4:0] id_rs2,
	input  logic             id_uses_rs2,
	input  logic             id_jump,
	input  logic             id_jalr,
	input  id_ex_t           id_ex,
	input  ex_mem_t          ex_mem,
	input  mem_wb_t          mem_wb,
	input  logic             branch_taken,
	output fwd_t             fwd,
	output logic       [1:0] jalr_fwd,
	output logic             stall,
	output logic             flush_if,
	output logic             flush_id
);

	logic load_use;
	logic jalr_wait;
	logic mem_hit_rs1;

	// ex/mem beats mem/wb, x0 never forwarded
	function automatic logic [1:0] fwd_sel(input logic [4:0] rs);
		if (ex_mem.reg_write && ex_mem.rd != 5'd0 && ex_mem.rd == rs) begin
			return 2'd1;
		end
		if (mem_wb.reg_write && mem_wb.rd != 5'd0 && mem_wb.rd == rs) begin
			return 2'd2;
		end
		return 2'd0;
	endfunction

	assign fwd.rs1_sel = fwd_sel(id_ex.rs1);
	assign fwd.rs2_sel = fwd_sel(id_ex.rs2);

	assign load_use = id_ex.ctrl.mem_read && id_ex.rd != 5'd0 &&
		(id_ex.rd == id_rs1 || (id_uses_rs2 && id_ex.rd == id_rs2));

	// jalr target is formed in decode, so a producer still in execute must drain
	assign jalr_wait = id_jalr && id_ex.ctrl.reg_write && id_ex.rd != 5'd0 &&
		id_ex.rd == id_rs1;

	// 1 takes the ex/mem result, 2 takes the load data on the port
	assign mem_hit_rs1 = ex_mem.reg_write && ex_mem.rd != 5'd0 && ex_mem.rd == id_rs1;
	assign jalr_fwd = !mem_hit_rs1 ? 2'd0 : ex_mem.mem_read ? 2'd2 : 2'd1;

	assign stall    = (load_use || jalr_wait) && !branch_taken;
	assign flush_if = branch_taken || (id_jump && !stall);
	assign flush_id = branch_taken;

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
// five-stage rv32i subset core with single-cycle instruction and data ports
`default_nettype none
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core import rv_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	output logic [`RV_PC_W-3:0]  imem_addr,
	input  word_t                imem_rdata,
	output logic                 dmem_ren,
	output logic                 dmem_wen,
	output logic [`RV_XLEN-3:0]  dmem_addr,
	output word_t                dmem_wdata,
	input  word_t                dmem_rdata
);

	localparam int XLEN = `RV_XLEN;
	localparam int PC_W = `RV_PC_W;

	logic [PC_W-1:0] pc, pc_next, pc_plus4, pc_id, pc_imm, jump_target;
	instr_u          if_id_instr;
	ctrl_t           id_ctrl;
	word_t           id_imm, id_rs1_data, id_rs2_data, jalr_src, jalr_sum;
	logic            id_jump, id_jalr, id_uses_rs2;
	id_ex_t          id_ex, id_ex_d;
	ex_mem_t         ex_mem, ex_mem_d;
	mem_wb_t         mem_wb;
	fwd_t            fwd;
	logic [1:0]      jalr_fwd;
	logic            stall, flush_if, flush_id;
	word_t           ex_a, ex_b_reg, ex_b, alu_result, ex_mem_value, wb_data;
	logic            alu_zero, branch_taken;

	// ------------------------------------------------------------------------
	// fetch
	// ------------------------------------------------------------------------
	assign pc_plus4  = pc + PC_W'(4);
	assign imem_addr = pc[PC_W-1:2];

	always_comb begin
		if (branch_taken)
			pc_next = id_ex.br_target;
		else if (stall)
			pc_next = pc;
		else if (id_jump)
			pc_next = jump_target;
		else
			pc_next = pc_plus4;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
			if_id_instr <= `RV_NOP;
		end else begin
			pc <= pc_next;
			if (flush_if) begin
				if_id_instr <= `RV_NOP;
			end else if (!stall) begin
				if_id_instr <= imem_rdata;
				pc_id <= pc;
			end
		end
	end

	// ------------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------------
	rv_decode u_decode (.instr(if_id_instr), .ctrl(id_ctrl), .imm(id_imm));

	rv_regfile u_regfile (
		.clk(clk), .rst_n(rst_n),
		.rs1(if_id_instr.r_fmt.rs1), .rs2(if_id_instr.r_fmt.rs2),
		.rd(mem_wb.rd), .wen(mem_wb.reg_write), .wdata(wb_data),
		.rs1_data(id_rs1_data), .rs2_data(id_rs2_data)
	);

	assign id_jump     = id_ctrl.link;
	assign id_jalr     = if_id_instr.r_fmt.opcode == OP_JALR;
	assign id_uses_rs2 = if_id_instr.r_fmt.opcode inside {OP_R, OP_STORE, OP_BRANCH};

	rv_hazard u_hazard (
		.id_rs1(if_id_instr.r_fmt.rs1), .id_rs2(if_id_instr.r_fmt.rs2),
		.id_uses_rs2(id_uses_rs2), .id_jump(id_jump), .id_jalr(id_jalr),
		.id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb), .branch_taken(branch_taken),
		.fwd(fwd), .jalr_fwd(jalr_fwd), .stall(stall),
		.flush_if(flush_if), .flush_id(flush_id)
	);

	// jalr base may still be in memory stage
	always_comb begin
		case (jalr_fwd)
			2'd1:    jalr_src = ex_mem_value;
			2'd2:    jalr_src = dmem_rdata;
			default: jalr_src = id_rs1_data;
		endcase
	end

	assign pc_imm      = pc_id + id_imm[PC_W-1:0];
	assign jalr_sum    = jalr_src + id_imm;
	assign jump_target = id_jalr ? {jalr_sum[PC_W-1:1], 1'b0} : pc_imm;

	assign id_ex_d = '{ctrl: id_ctrl, rs1_data: id_rs1_data, rs2_data: id_rs2_data,
		imm: id_imm, rs1: if_id_instr.r_fmt.rs1, rs2: if_id_instr.r_fmt.rs2,
		rd: if_id_instr.r_fmt.rd, pc_link: pc_id + PC_W'(4), br_target: pc_imm};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex.ctrl <= '0;
		end else begin
			id_ex <= id_ex_d;
			// bubble on stall or taken branch
			if (stall || flush_id)
				id_ex.ctrl <= '0;
		end
	end

	// ------------------------------------------------------------------------
	// execute
	// ------------------------------------------------------------------------
	assign ex_mem_value = ex_mem.link ? XLEN'(ex_mem.pc_link) : ex_mem.alu_result;

	always_comb begin
		case (fwd.rs1_sel)
			2'd1:    ex_a = ex_mem_value;
			2'd2:    ex_a = wb_data;
			default: ex_a = id_ex.rs1_data;
		endcase
		case (fwd.rs2_sel)
			2'd1:    ex_b_reg = ex_mem_value;
			2'd2:    ex_b_reg = wb_data;
			default: ex_b_reg = id_ex.rs2_data;
		endcase
	end

	assign ex_b = id_ex.ctrl.alu_src ? id_ex.imm : ex_b_reg;

	rv_alu u_alu (.a(ex_a), .b(ex_b), .alu_ctrl(id_ex.ctrl.alu_ctrl),
		.result(alu_result), .zero(alu_zero));

	assign branch_taken = id_ex.ctrl.branch && (alu_zero ^ id_ex.ctrl.branch_ne);

	assign ex_mem_d = '{mem_read: id_ex.ctrl.mem_read, mem_write: id_ex.ctrl.mem_write,
		mem_to_reg: id_ex.ctrl.mem_to_reg, reg_write: id_ex.ctrl.reg_write,
		link: id_ex.ctrl.link, alu_result: alu_result, store_data: ex_b_reg,
		rd: id_ex.rd, pc_link: id_ex.pc_link};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.mem_read  <= 1'b0;
			ex_mem.mem_write <= 1'b0;
			ex_mem.reg_write <= 1'b0;
		end else begin
			ex_mem <= ex_mem_d;
		end
	end

	// ------------------------------------------------------------------------
	// memory and writeback
	// ------------------------------------------------------------------------
	assign dmem_ren   = ex_mem.mem_read;
	assign dmem_wen   = ex_mem.mem_write;
	assign dmem_addr  = ex_mem.alu_result[XLEN-1:2];
	assign dmem_wdata = ex_mem.store_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb.reg_write <= 1'b0;
		end else begin
			mem_wb <= '{reg_write: ex_mem.reg_write, mem_to_reg: ex_mem.mem_to_reg,
				link: ex_mem.link, alu_result: ex_mem.alu_result, mem_data: dmem_rdata,
				rd: ex_mem.rd, pc_link: ex_mem.pc_link};
		end
	end

	assign wb_data = mem_wb.link ? XLEN'(mem_wb.pc_link) :
		mem_wb.mem_to_reg ? mem_wb.mem_data : mem_wb.alu_result;

endmodule

`default_nettype wire

//--- sim/rv_core_checker.sv
// assertions on the core's memory strobes and fetch hold, bound into the core by the testbench
`default_nettype none
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core_checker import rv_pkg::*; (
	input logic                clk,
	input logic                rst_n,
	input logic                dmem_ren,
	input logic                dmem_wen,
	input logic [`RV_PC_W-3:0] imem_addr,
	input logic                stall
);

	// one memory op per cycle
	strobe_excl: assert property (@(posedge clk) !(dmem_ren && dmem_wen))
		else $error("data read and write strobes high in the same cycle");

	reset_quiet: assert property (@(posedge clk)
		(!rst_n && $past(!rst_n)) |-> (!dmem_ren && !dmem_wen))
		else $error("data strobe high while reset is asserted");

	// a stalled fetch keeps its address
	stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(imem_addr))
		else $error("instruction address moved during a stall");

endmodule

`default_nettype wire

//--- sim/rv_core_tb.sv
// testbench for the core: memory models, instruction-set reference, store checks and watchdog
`default_nettype none
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core_tb;

	// {funct7, funct3} of the register ops
	localparam logic [9:0] FN_ADD = 10'h000;
	localparam logic [9:0] FN_SUB = 10'h100;
	localparam logic [9:0] FN_AND = 10'h007;
	localparam logic [9:0] FN_OR  = 10'h006;
	localparam logic [9:0] FN_SLT = 10'h002;
	// jal x0, 0
	localparam logic [31:0] HALT = 32'h0000_006f;

	logic                  clk;
	logic                  rst_n;
	logic [`RV_PC_W-3:0]   imem_addr;
	logic [31:0]           imem_rdata;
	logic                  dmem_ren;
	logic                  dmem_wen;
	logic [`RV_XLEN-3:0]   dmem_addr;
	logic [31:0]           dmem_wdata;
	logic [31:0]           dmem_rdata;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] ref_mem [256];
	logic [31:0] prog [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	integer      seed;
	int          errors;
	int          checks;
	int          stores;

	rv_core dut0 (
		.clk(clk), .rst_n(rst_n),
		.imem_addr(imem_addr), .imem_rdata(imem_rdata),
		.dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata)
	);

	bind rv_core rv_core_checker u_checker (
		.clk(clk), .rst_n(rst_n), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
		.imem_addr(imem_addr), .stall(stall)
	);

	assign imem_rdata = imem[imem_addr];
	// load data only under the read strobe
	assign dmem_rdata = dmem_ren ? dmem[dmem_addr[7:0]] : '0;

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ------------------------------------------------------------------------
	// instruction encoding
	// ------------------------------------------------------------------------
	function automatic logic [31:0] r_type(input logic [9:0] fn, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		return {fn[9:3], rs2, rs1, fn[2:0], rd, 7'h33};
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return i_type(7'h13, 3'd0, rd, rs1, imm);
	endfunction

	function automatic logic [31:0] lw(input logic [4:0] rd, input logic [11:0] imm);
		return i_type(7'h03, 3'd2, rd, 5'd0, imm);
	endfunction

	function automatic logic [31:0] jalr(input logic [4:0] rs1, input logic [11:0] imm);
		return i_type(7'h67, 3'd0, 5'd0, rs1, imm);
	endfunction

	function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, 5'd0, 3'd2, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input int off);
		logic [12:0] o;
		o = off[12:0];
		return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'h63};
	endfunction

	function automatic logic [31:0] j_type(input logic [4:0] rd, input int off);
		logic [20:0] o;
		o = off[20:0];
		return {o[20], o[10:1], o[11], o[19:12], rd, 7'h6f};
	endfunction

	function automatic logic [31:0] fill_word(input logic [7:0] a);
		return {a ^ 8'ha5, a, ~a, a + 8'h31};
	endfunction

	// ------------------------------------------------------------------------
	// instruction-set reference, runs until the self jump
	// ------------------------------------------------------------------------
	function automatic void ref_run();
		logic [31:0] x [32];
		logic [31:0] pc, nxt, w, a, b, res, ea;
		logic [31:0] imm_i, imm_s, imm_b, imm_j;
		logic        wr;
		for (int i = 0; i < 32; i++) begin
			x[i] = '0;
		end
		pc = '0;
		for (int step = 0; step < 4096; step++) begin
			w = imem[pc[9:2]];
			if (w == HALT)
				break;
			a = x[w[19:15]];
			b = x[w[24:20]];
			imm_i = {{20{w[31]}}, w[31:20]};
			imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
			imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			nxt = pc + 32'd4;
			wr = 1'b0;
			res = '0;
			case (w[6:0])
				7'h33: begin
					wr = 1'b1;
					case (w[14:12])
						3'd0:    res = w[30] ? a - b : a + b;
						3'd2:    res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						3'd6:    res = a | b;
						3'd7:    res = a & b;
						default: res = '0;
					endcase
				end
				7'h13: begin
					wr = 1'b1;
					res = a + imm_i;
				end
				7'h03: begin
					wr = 1'b1;
					ea = a + imm_i;
					res = ref_mem[ea[9:2]];
				end
				7'h23: begin
					ea = a + imm_s;
					ref_mem[ea[9:2]] = b;
					exp_addr.push_back({2'b00, ea[31:2]});
					exp_data.push_back(b);
				end
				7'h63: begin
					// beq when funct3[0] is 0, bne otherwise
					if ((a == b) != w[12])
						nxt = pc + imm_b;
				end
				7'h6f: begin
					wr = 1'b1;
					res = pc + 32'd4;
					nxt = pc + imm_j;
				end
				7'h67: begin
					wr = 1'b1;
					res = pc + 32'd4;
					ea = a + imm_i;
					nxt = {ea[31:1], 1'b0};
				end
				default: ;
			endcase
			if (wr && w[11:7] != 5'd0)
				x[w[11:7]] = res;
			pc = nxt;
		end
	endfunction

	// ------------------------------------------------------------------------
	// checking
	// ------------------------------------------------------------------------
	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic print_counts();
		$display("stores %0d, checks %0d, errors %0d", stores, checks, errors);
	endtask

	// outputs are settled mid cycle
	always @(negedge clk) begin
		if (rst_n && dmem_wen) begin
			dmem[dmem_addr[7:0]] = dmem_wdata;
			stores++;
			if (exp_addr.size() == 0) begin
				errors++;
				$display("unexpected store at %0t to word %h with data %h",
					$time, dmem_addr, dmem_wdata);
			end else begin
				check_eq({2'b00, dmem_addr}, exp_addr.pop_front(), "store word address");
				check_eq(dmem_wdata, exp_data.pop_front(), "store data");
			end
		end
	end

	initial begin
		repeat (`RV_SIM_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, %0d expected stores did not finish",
			`RV_SIM_CYCLES, exp_addr.size());
		print_counts();
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ------------------------------------------------------------------------
	// programs
	// ------------------------------------------------------------------------
	task automatic run_program(input string name);
		logic [31:0] r;
		@(posedge clk);
		#0.5;
		rst_n = 1'b0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : `RV_NOP;
			dmem[i] = fill_word(8'(i));
		end
		// words summed by the branch loop
		for (int k = 32; k < 40; k++) begin
			r = $random(seed);
			dmem[k] = r;
		end
		ref_mem = dmem;
		exp_addr.delete();
		exp_data.delete();
		ref_run();
		$display("%s: %0d stores expected", name, exp_addr.size());
		repeat (8) @(posedge clk);
		#0.5;
		rst_n = 1'b1;
		while (exp_addr.size() != 0) @(negedge clk);
		// room for stray stores from flushed slots
		repeat (16) @(negedge clk);
	endtask

	task automatic forwarding_prog();
		logic [31:0] r1, r2;
		r1 = $random(seed);
		r2 = $random(seed);
		prog.delete();
		prog.push_back(addi(5'd1, 5'd0, r1[11:0]));
		prog.push_back(addi(5'd2, 5'd0, r2[11:0]));
		prog.push_back(r_type(FN_ADD, 5'd3, 5'd1, 5'd2));
		prog.push_back(r_type(FN_SUB, 5'd4, 5'd3, 5'd1));
		prog.push_back(sw(5'd4, 12'h100));
		prog.push_back(r_type(FN_AND, 5'd5, 5'd4, 5'd3));
		prog.push_back(r_type(FN_OR, 5'd6, 5'd5, 5'd2));
		prog.push_back(r_type(FN_SLT, 5'd7, 5'd6, 5'd4));
		prog.push_back(r_type(FN_SLT, 5'd8, 5'd4, 5'd6));
		prog.push_back(sw(5'd3, 12'h104));
		prog.push_back(sw(5'd5, 12'h108));
		prog.push_back(sw(5'd6, 12'h10c));
		prog.push_back(sw(5'd7, 12'h110));
		prog.push_back(sw(5'd8, 12'h114));
		prog.push_back(addi(5'd9, 5'd7, 12'hfff));
		prog.push_back(sw(5'd9, 12'h118));
		prog.push_back(HALT);
	endtask

	task automatic load_use_prog();
		prog.delete();
		prog.push_back(lw(5'd1, 12'h020));
		prog.push_back(r_type(FN_ADD, 5'd2, 5'd1, 5'd1));
		prog.push_back(sw(5'd2, 12'h140));
		prog.push_back(lw(5'd3, 12'h024));
		prog.push_back(sw(5'd3, 12'h144));
		prog.push_back(lw(5'd4, 12'h028));
		prog.push_back(addi(5'd5, 5'd4, 12'd5));
		prog.push_back(sw(5'd5, 12'h148));
		prog.push_back(lw(5'd6, 12'h140));
		prog.push_back(sw(5'd6, 12'h14c));
		prog.push_back(HALT);
	endtask

	task automatic branch_prog();
		prog.delete();
		prog.push_back(addi(5'd1, 5'd0, 12'd0));
		prog.push_back(addi(5'd2, 5'd0, 12'd0));
		prog.push_back(addi(5'd3, 5'd0, 12'd32));
		// loop over the eight random words
		prog.push_back(i_type(7'h03, 3'd2, 5'd4, 5'd2, 12'h080));
		prog.push_back(r_type(FN_ADD, 5'd1, 5'd1, 5'd4));
		prog.push_back(addi(5'd2, 5'd2, 12'd4));
		prog.push_back(b_type(3'd1, 5'd2, 5'd3, -12));
		prog.push_back(b_type(3'd0, 5'd1, 5'd0, 16));
		prog.push_back(b_type(3'd0, 5'd0, 5'd0, 12));
		prog.push_back(sw(5'd1, 12'h1f0));
		prog.push_back(sw(5'd1, 12'h1f4));
		prog.push_back(sw(5'd1, 12'h0c0));
		prog.push_back(HALT);
	endtask

	task automatic jump_prog();
		prog.delete();
		prog.push_back(addi(5'd10, 5'd0, 12'd7));
		prog.push_back(j_type(5'd1, 28));
		prog.push_back(sw(5'd1, 12'h060));
		prog.push_back(j_type(5'd5, 24));
		// skipped by the return to link plus 8
		prog.push_back(sw(5'd10, 12'h1f8));
		prog.push_back(sw(5'd10, 12'h1fc));
		prog.push_back(sw(5'd5, 12'h064));
		prog.push_back(HALT);
		prog.push_back(jalr(5'd1, 12'd0));
		prog.push_back(addi(5'd7, 5'd5, 12'd8));
		prog.push_back(jalr(5'd7, 12'd0));
	endtask

	task automatic zero_reg_prog();
		prog.delete();
		prog.push_back(addi(5'd1, 5'd0, 12'd9));
		prog.push_back(addi(5'd0, 5'd0, 12'd55));
		prog.push_back(r_type(FN_ADD, 5'd0, 5'd1, 5'd1));
		prog.push_back(r_type(FN_ADD, 5'd3, 5'd0, 5'd1));
		prog.push_back(lw(5'd0, 12'h020));
		prog.push_back(sw(5'd0, 12'h170));
		prog.push_back(r_type(FN_ADD, 5'd2, 5'd0, 5'd0));
		prog.push_back(sw(5'd2, 12'h174));
		prog.push_back(sw(5'd3, 12'h178));
		prog.push_back(HALT);
	endtask

	initial begin
		rst_n = 1'b0;
		seed = 32'ha1d86866;
		errors = 0;
		checks = 0;
		stores = 0;
		forwarding_prog();
		run_program("forwarding");
		load_use_prog();
		run_program("load-use");
		branch_prog();
		run_program("branch loop");
		jump_prog();
		run_program("jal and jalr");
		zero_reg_prog();
		run_program("x0 writes");
		print_counts();
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_hazard.sv
verilog/rv_core.sv
sim/rv_core_checker.sv
sim/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# builds the core testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module rv_core_tb -Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vrv_core_tb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx 'TEST RESULT: PASS'; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
